/* dcache_top.f */
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_array.sv
src/dcache_fsm.sv
src/dcache_top.sv
verif/dcache_clk_gen.sv
verif/dcache_tb.sv

/* src/dcache_addr_pkg.sv */
`default_nettype none

`include "dcache_params.svh"

package dcache_addr_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_TAG_W-1:0]  tag_t;
    typedef logic [`DCACHE_IDX_W-1:0]  idx_t;

    typedef struct packed {
        tag_t                         tag;
        idx_t                         idx;
        logic                         blkoff;
        logic [`DCACHE_BYTOFF_W-1:0]  bytoff;
    } addr_t;

    // held by the cpu until hit
    typedef struct packed {
        logic  ren;
        logic  wen;
        logic  halt;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  hit;
        word_t rdata;
        logic  flushed;
    } cpu_rsp_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* src/dcache_array.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_array (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  dcache_addr_pkg::addr_t                        lookup,
    input  dcache_ctrl_pkg::array_cmd_t                   cmd,
    output logic                                          hit,
    output dcache_ctrl_pkg::way_t                         hit_way,
    output dcache_addr_pkg::word_t                        rdata,
    output dcache_ctrl_pkg::way_t                         victim,
    output dcache_ctrl_pkg::frame_t [`DCACHE_WAYS-1:0]    set_frames
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    // per-way state bits
    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid_q;
    logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] dirty_q;
    // lru bit names the way to evict next
    logic [`DCACHE_SETS-1:0]                   lru_q;

    tag_t                          tag_mem  [`DCACHE_SETS][`DCACHE_WAYS];
    word_t [`DCACHE_BLK_WORDS-1:0] data_mem [`DCACHE_SETS][`DCACHE_WAYS];

    // frames of the looked-up set
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            set_frames[w].valid = valid_q[lookup.idx][w];
            set_frames[w].dirty = dirty_q[lookup.idx][w];
            set_frames[w].tag   = tag_mem[lookup.idx][w];
            set_frames[w].data  = data_mem[lookup.idx][w];
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (set_frames[w].valid && (set_frames[w].tag == lookup.tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign rdata  = set_frames[hit_way].data[lookup.blkoff];
    assign victim = way_t'(lru_q[lookup.idx]);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (cmd.en && cmd.clear) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (cmd.en) begin
            if (cmd.flags_we) begin
                valid_q[cmd.idx][cmd.way] <= cmd.valid;
                dirty_q[cmd.idx][cmd.way] <= cmd.dirty;
            end
            // other way becomes the victim
            if (cmd.lru_touch) begin
                lru_q[cmd.idx] <= ~cmd.way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd.en && !cmd.clear) begin
            if (cmd.tag_we) begin
                tag_mem[cmd.idx][cmd.way] <= cmd.tag;
            end
            if (cmd.word_we) begin
                data_mem[cmd.idx][cmd.way][cmd.word_sel] <= cmd.wdata;
            end
        end
    end

    // flush clear and a data write must not share a cycle
    a_clear_no_word: assert property (
        @(posedge CLK) disable iff (!nRST)
        (cmd.en && cmd.clear) |-> !cmd.word_we
    );

endmodule

`default_nettype wire

/* src/dcache_ctrl_pkg.sv */
`default_nettype none

`include "dcache_params.svh"

package dcache_ctrl_pkg;

    import dcache_addr_pkg::*;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    typedef struct packed {
        logic                              valid;
        logic                              dirty;
        tag_t                              tag;
        word_t [`DCACHE_BLK_WORDS-1:0]     data;
    } frame_t;

    // one array update per cycle
    typedef struct packed {
        logic  en;
        idx_t  idx;
        way_t  way;
        logic  word_we;
        logic  word_sel;
        word_t wdata;
        logic  tag_we;
        tag_t  tag;
        logic  flags_we;
        logic  valid;
        logic  dirty;
        logic  lru_touch;
        logic  clear;
    } array_cmd_t;

    typedef enum logic [3:0] {
        LOOKUP,
        WB1,
        WB2,
        AL1,
        AL2,
        FLUSH_SCAN,
        FLUSH_WB1,
        FLUSH_WB2,
        DONE
    } fsm_state_t;

endpackage

`default_nettype wire

/* src/dcache_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_fsm (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  dcache_addr_pkg::cpu_req_t                     cpu_req,
    output dcache_addr_pkg::cpu_rsp_t                     cpu_rsp,
    output dcache_addr_pkg::mem_req_t                     mem_req,
    input  dcache_addr_pkg::word_t                        mem_dload,
    input  logic                                          mem_wait,
    output dcache_addr_pkg::addr_t                        lookup,
    output dcache_ctrl_pkg::array_cmd_t                   cmd,
    input  logic                                          hit,
    input  dcache_ctrl_pkg::way_t                         hit_way,
    input  dcache_addr_pkg::word_t                        rdata,
    input  dcache_ctrl_pkg::way_t                         victim,
    input  dcache_ctrl_pkg::frame_t [`DCACHE_WAYS-1:0]    set_frames
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    fsm_state_t state, next_state;
    // victim way on a miss, way counter during flush
    way_t       way_q, way_d;
    idx_t       set_q, set_d;
    // word address on the memory side
    addr_t      addr_q, addr_d;

    always_comb begin
        if (state == LOOKUP) begin
            lookup = cpu_req.addr;
        end else if (state == FLUSH_SCAN) begin
            lookup = '{tag: '0, idx: set_q, blkoff: 1'b0, bytoff: '0};
        end else begin
            lookup = addr_q;
        end
    end

    always_comb begin
        next_state = state;
        way_d      = way_q;
        set_d      = set_q;
        addr_d     = addr_q;

        cmd        = '0;
        cmd.idx    = lookup.idx;
        cmd.way    = way_q;

        mem_req       = '0;
        mem_req.addr  = addr_q;
        mem_req.wdata = set_frames[way_q].data[addr_q.blkoff];

        cpu_rsp         = '0;
        cpu_rsp.flushed = (state == DONE);

        case (state)
            LOOKUP: begin
                if (cpu_req.halt) begin
                    next_state = FLUSH_SCAN;
                    set_d      = '0;
                    way_d      = '0;
                end else if (cpu_req.ren || cpu_req.wen) begin
                    if (hit) begin
                        cpu_rsp.hit   = 1'b1;
                        cpu_rsp.rdata = rdata;
                        cmd.en        = 1'b1;
                        cmd.way       = hit_way;
                        cmd.lru_touch = 1'b1;
                        if (cpu_req.wen) begin
                            cmd.word_we  = 1'b1;
                            cmd.word_sel = cpu_req.addr.blkoff;
                            cmd.wdata    = cpu_req.wdata;
                            cmd.flags_we = 1'b1;
                            cmd.valid    = 1'b1;
                            cmd.dirty    = 1'b1;
                        end
                    end else begin
                        way_d = victim;
                        if (set_frames[victim].valid && set_frames[victim].dirty) begin
                            next_state = WB1;
                            addr_d = '{tag: set_frames[victim].tag, idx: cpu_req.addr.idx,
                                       blkoff: 1'b0, bytoff: '0};
                        end else begin
                            next_state = AL1;
                            addr_d = '{tag: cpu_req.addr.tag, idx: cpu_req.addr.idx,
                                       blkoff: 1'b0, bytoff: '0};
                        end
                    end
                end
            end

            WB1, FLUSH_WB1: begin
                mem_req.wen = 1'b1;
                if (!mem_wait) begin
                    addr_d.blkoff = 1'b1;
                    next_state    = (state == WB1) ? WB2 : FLUSH_WB2;
                end
            end

            WB2: begin
                mem_req.wen = 1'b1;
                if (!mem_wait) begin
                    next_state = AL1;
                    addr_d = '{tag: cpu_req.addr.tag, idx: cpu_req.addr.idx,
                               blkoff: 1'b0, bytoff: '0};
                end
            end

            AL1, AL2: begin
                mem_req.ren = 1'b1;
                if (!mem_wait) begin
                    cmd.en       = 1'b1;
                    cmd.word_we  = 1'b1;
                    cmd.word_sel = addr_q.blkoff;
                    cmd.wdata    = mem_dload;
                    cmd.flags_we = 1'b1;
                    cmd.dirty    = 1'b0;
                    if (state == AL1) begin
                        // block stays invalid until its second word lands
                        cmd.valid     = 1'b0;
                        addr_d.blkoff = 1'b1;
                        next_state    = AL2;
                    end else begin
                        cmd.valid  = 1'b1;
                        cmd.tag_we = 1'b1;
                        cmd.tag    = addr_q.tag;
                        next_state = LOOKUP;
                    end
                end
            end

            FLUSH_SCAN: begin
                if (set_frames[way_q].valid && set_frames[way_q].dirty) begin
                    next_state = FLUSH_WB1;
                    addr_d = '{tag: set_frames[way_q].tag, idx: set_q,
                               blkoff: 1'b0, bytoff: '0};
                end else if (way_q != way_t'(`DCACHE_WAYS-1)) begin
                    way_d = way_q + 1'b1;
                end else if (set_q != idx_t'(`DCACHE_SETS-1)) begin
                    way_d = '0;
                    set_d = set_q + 1'b1;
                end else begin
                    cmd.en     = 1'b1;
                    cmd.clear  = 1'b1;
                    next_state = DONE;
                end
            end

            FLUSH_WB2: begin
                mem_req.wen = 1'b1;
                if (!mem_wait) begin
                    // rescan sees it clean and moves on
                    cmd.en       = 1'b1;
                    cmd.flags_we = 1'b1;
                    cmd.valid    = 1'b0;
                    cmd.dirty    = 1'b0;
                    next_state   = FLUSH_SCAN;
                end
            end

            DONE: begin
                next_state = DONE;
            end

            default: begin
                next_state = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state  <= LOOKUP;
            way_q  <= '0;
            set_q  <= '0;
            addr_q <= '0;
        end else begin
            state  <= next_state;
            way_q  <= way_d;
            set_q  <= set_d;
            addr_q <= addr_d;
        end
    end

    a_no_rd_wr: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen)
    );

    // request held through memory wait states
    a_addr_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((mem_req.ren || mem_req.wen) && mem_wait) |=> $stable(mem_req.addr)
    );

endmodule

`default_nettype wire

/* src/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DCACHE_WORD_W    32
`define DCACHE_SETS      8
`define DCACHE_IDX_W     3
`define DCACHE_WAYS      2
`define DCACHE_BLK_WORDS 2

// address splits into tag idx blkoff bytoff
`define DCACHE_TAG_W     26
`define DCACHE_BYTOFF_W  2

`endif

/* src/dcache_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dcache_addr_pkg::cpu_req_t cpu_req,
    output dcache_addr_pkg::cpu_rsp_t cpu_rsp,
    output dcache_addr_pkg::mem_req_t mem_req,
    input  dcache_addr_pkg::word_t    mem_dload,
    input  logic                      mem_wait
);
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;

    addr_t                     lookup;
    array_cmd_t                cmd;
    logic                      hit;
    way_t                      hit_way;
    word_t                     rdata;
    way_t                      victim;
    frame_t [`DCACHE_WAYS-1:0] set_frames;

    dcache_array u_array (
        .CLK        (CLK),
        .nRST       (nRST),
        .lookup     (lookup),
        .cmd        (cmd),
        .hit        (hit),
        .hit_way    (hit_way),
        .rdata      (rdata),
        .victim     (victim),
        .set_frames (set_frames)
    );

    dcache_fsm u_fsm (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_dload  (mem_dload),
        .mem_wait   (mem_wait),
        .lookup     (lookup),
        .cmd        (cmd),
        .hit        (hit),
        .hit_way    (hit_way),
        .rdata      (rdata),
        .victim     (victim),
        .set_frames (set_frames)
    );

endmodule

`default_nettype wire

/* verif/dcache_clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_clk_gen (
    output logic CLK,
    output logic nRST
);
    localparam real HALF_PERIOD = 4.0;

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // reset held for two rising edges
    initial begin
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/dcache_patterns.txt */
# op addr data expected; R: data = memory transfers, expected = read word
# W: data = write word, expected = memory transfers; H: expected = write transfers; C: memory word
R 00000008 00000002 5a5a0008
R 00000008 00000000 5a5a0008
W 00000010 cafe0001 00000002
R 00000010 00000000 cafe0001
R 00000014 00000000 5a5a0014
W 00000018 beef0018 00000002
R 00000058 00000002 5a5a0058
R 00000098 00000004 5a5a0098
C 00000018 00000000 beef0018
C 0000001c 00000000 5a5a001c
R 00000018 00000002 beef0018
R 00000020 00000002 5a5a0020
R 00000060 00000002 5a5a0060
R 00000020 00000000 5a5a0020
R 000000a0 00000002 5a5a00a0
R 00000024 00000000 5a5a0024
R 00000060 00000002 5a5a0060
W 0000002c 12345678 00000002
W 00000028 87654321 00000000
W 00000004 a5a5a5a5 00000002
H 00000000 00000000 00000006
C 00000010 00000000 cafe0001
C 00000014 00000000 5a5a0014
C 00000028 00000000 87654321
C 0000002c 00000000 12345678
C 00000004 00000000 a5a5a5a5
C 00000000 00000000 5a5a0000

/* verif/dcache_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_tb;
    import dcache_addr_pkg::*;

    localparam int DRIVE_DELAY    = 1;
    localparam int MAX_PATTERNS   = 64;
    localparam int CYCLES_PER_PAT = 40;

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    word_t    mem_dload;
    logic     mem_wait;

    // behavioral memory of 1024 words
    logic [31:0] mem_words [0:1023];
    int          rd_xfers;
    int          wr_xfers;
    logic        wait_pending;
    logic [31:0] held_addr;
    logic [31:0] held_wdata;

    logic [7:0]  pat_op   [MAX_PATTERNS];
    logic [31:0] pat_addr [MAX_PATTERNS];
    logic [31:0] pat_data [MAX_PATTERNS];
    logic [31:0] pat_exp  [MAX_PATTERNS];
    int          n_pat;

    int     errors;
    int     cycles;
    int     cycle_limit;
    integer seed;

    dcache_clk_gen u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    dcache_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_dload (mem_dload),
        .mem_wait  (mem_wait)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    assign mem_dload = mem_words[mem_req.addr[11:2]];

    // random wait states in about one cycle of four
    always @(posedge CLK) begin
        #(DRIVE_DELAY);
        mem_wait = (($random(seed) & 3) == 0);
    end

    // transfers land at the next edge so sample in mid cycle
    always @(negedge CLK) begin
        if (nRST && (mem_req.ren || mem_req.wen)) begin
            if (mem_req.addr >= 32'h1000) begin
                errors++;
                $display("memory access outside the modeled range at %0t ns", $time);
            end
            if (wait_pending) begin
                check_value("mem_req.addr", mem_req.addr, held_addr);
                if (mem_req.wen) begin
                    check_value("mem_req.wdata", mem_req.wdata, held_wdata);
                end
            end
            if (!mem_wait) begin
                wait_pending = 1'b0;
                if (mem_req.wen) begin
                    mem_words[mem_req.addr[11:2]] = mem_req.wdata;
                    wr_xfers++;
                end else begin
                    rd_xfers++;
                end
            end else begin
                wait_pending = 1'b1;
                held_addr    = mem_req.addr;
                held_wdata   = mem_req.wdata;
            end
        end else if (wait_pending) begin
            errors++;
            wait_pending = 1'b0;
            $display("memory request dropped during a wait state at %0t ns", $time);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run passed %0d cycles without finishing", cycle_limit);
            $display("errors: %0d", errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic load_patterns();
        int    fd;
        int    code;
        string line;
        string opstr;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("verif/dcache_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file");
            return;
        end
        while (!$feof(fd) && n_pat < MAX_PATTERNS) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                break;
            end
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %h %h %h", opstr, a, d, e) == 4) begin
                    pat_op[n_pat]   = opstr.getc(0);
                    pat_addr[n_pat] = a;
                    pat_data[n_pat] = d;
                    pat_exp[n_pat]  = e;
                    n_pat++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one cpu access that ends when hit is seen in mid cycle
    task automatic run_access(input logic [7:0] op, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] expected);
        int          rd0;
        int          wr0;
        logic [31:0] got;
        rd0         = rd_xfers;
        wr0         = wr_xfers;
        cpu_req     = '0;
        cpu_req.ren = (op == "R");
        cpu_req.wen = (op == "W");
        cpu_req.addr  = addr;
        cpu_req.wdata = data;
        @(negedge CLK);
        while (!cpu_rsp.hit) begin
            @(negedge CLK);
        end
        got = cpu_rsp.rdata;
        if (op == "R") begin
            check_value("cpu_rsp.rdata", got, expected);
            check_value("memory transfers", (rd_xfers - rd0) + (wr_xfers - wr0), data);
        end else begin
            check_value("memory transfers", (rd_xfers - rd0) + (wr_xfers - wr0), expected);
        end
        @(posedge CLK);
        #(DRIVE_DELAY);
        cpu_req = '0;
    endtask

    task automatic run_halt(input logic [31:0] expected);
        int wr0;
        wr0          = wr_xfers;
        cpu_req      = '0;
        cpu_req.halt = 1'b1;
        @(negedge CLK);
        while (!cpu_rsp.flushed) begin
            @(negedge CLK);
        end
        check_value("flush write transfers", wr_xfers - wr0, expected);
        @(posedge CLK);
        #(DRIVE_DELAY);
    endtask

    initial begin
        cpu_req      = '0;
        mem_wait     = 1'b0;
        seed         = 32'h823a;
        errors       = 0;
        cycles       = 0;
        cycle_limit  = 0;
        n_pat        = 0;
        rd_xfers     = 0;
        wr_xfers     = 0;
        wait_pending = 1'b0;
        held_addr    = '0;
        held_wdata   = '0;
        for (int i = 0; i < 1024; i++) begin
            mem_words[i] = (i << 2) ^ 32'h5a5a0000;
        end
        load_patterns();
        cycle_limit = CYCLES_PER_PAT * (n_pat + 1);

        @(posedge nRST);
        @(posedge CLK);
        #(DRIVE_DELAY);
        check_value("cpu_rsp.flushed", cpu_rsp.flushed, 1'b0);
        check_value("mem_req.ren", mem_req.ren, 1'b0);
        check_value("mem_req.wen", mem_req.wen, 1'b0);

        for (int p = 0; p < n_pat; p++) begin
            case (pat_op[p])
                "R", "W": run_access(pat_op[p], pat_addr[p], pat_data[p], pat_exp[p]);
                "H": run_halt(pat_exp[p]);
                "C": check_value("memory word", mem_words[pat_addr[p][11:2]], pat_exp[p]);
                default: begin
                    errors++;
                    $display("unknown opcode in pattern line %0d", p);
                end
            endcase
        end

        $display("errors: %0d, patterns: %0d", errors, n_pat);
        if (errors == 0 && n_pat > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
